//--- hyper_pkg.sv
// Shared definitions for the HyperBus PHY
// Bus widths, fixed latencies and the controller state type

package hyper_pkg;

    localparam int NR_CS       = 2;
    localparam int BURST_WIDTH = 12;
    localparam int ADDR_WIDTH  = 32;
    localparam int WORD_WIDTH  = 16;
    localparam int STRB_WIDTH  = WORD_WIDTH / 8;  // One strobe per byte lane
    localparam int CA_WIDTH    = 48;

    // Latencies in bus clock cycles
    localparam int T_ACC = 6;
    localparam int T_RWR = 4;

    // Wide enough for the doubled access latency
    localparam int CNT_WIDTH = $clog2(2 * T_ACC + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,     // Three command-address cycles
        ST_LAT,     // Initial access latency
        ST_WDATA,
        ST_WSTALL,  // Waiting for a write word, clock stopped
        ST_RDATA,
        ST_RSTALL,  // Receive register full, clock stopped
        ST_RECOV    // Read-write recovery, chip select high
    } hyper_state_t;

endpackage

//--- hyper_ca_gen.sv
// Command-address word builder
// Returns one 16-bit slice of the 48-bit CA word per command cycle
`timescale 1ns/1ns

module hyper_ca_gen
    import hyper_pkg::*;
(
    input  logic                  read_i,
    input  logic [ADDR_WIDTH-1:0] address_i,
    input  logic [1:0]            ca_sel_i,
    output logic [WORD_WIDTH-1:0] ca_word_o
);

    logic [CA_WIDTH-1:0] ca;

    // Memory space, linear burst
    assign ca = {read_i, 1'b0, 1'b1,
                 address_i[ADDR_WIDTH-1:3],  // Row and upper column
                 13'b0,
                 address_i[2:0]};            // Lower column

    always_comb begin
        case (ca_sel_i)
            2'd0:    ca_word_o = ca[47:32];
            2'd1:    ca_word_o = ca[31:16];
            2'd2:    ca_word_o = ca[15:0];
            default: ca_word_o = '0;
        endcase
    end

endmodule

//--- hyper_ctrl_fsm.sv
// Transaction controller for the HyperBus PHY
// Command, latency, burst and recovery sequencing with clock-enable control
`timescale 1ns/1ns

module hyper_ctrl_fsm
    import hyper_pkg::*;
(
    input  logic                   clk0,
    input  logic                   rst_ni,

    input  logic                   trans_valid_i,
    output logic                   trans_ready_o,
    input  logic [ADDR_WIDTH-1:0]  trans_address_i,
    input  logic                   trans_write_i,
    input  logic [NR_CS-1:0]       trans_cs_i,
    input  logic [BURST_WIDTH-1:0] trans_burst_i,

    input  logic                   tx_valid_i,

    input  logic                   rx_full_i,
    input  logic                   rx_ready_i,
    input  logic                   rx_take_i,

    input  logic                   hyper_rwds_i,

    output hyper_state_t           state_o,
    output logic [1:0]             ca_sel_o,
    output logic                   last_word_o,
    output logic [ADDR_WIDTH-1:0]  addr_o,
    output logic                   read_o,
    output logic [NR_CS-1:0]       hyper_cs_no,
    output logic                   hyper_ck_en_o,
    output logic                   b_resp_valid_o
);

    hyper_state_t           state_q;
    logic [1:0]             ca_sel_q;
    logic [CNT_WIDTH-1:0]   lat_cnt_q;
    logic [CNT_WIDTH-1:0]   rec_cnt_q;
    logic [BURST_WIDTH-1:0] burst_q;
    logic [NR_CS-1:0]       cs_q;
    logic                   write_q;
    logic [ADDR_WIDTH-1:0]  addr_q;
    logic                   rd_stall;
    logic                   cs_active;

    assign rd_stall  = rx_full_i && !rx_ready_i;
    assign last_word_o = (burst_q == BURST_WIDTH'(1));

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            ca_sel_q  <= '0;
            lat_cnt_q <= '0;
            rec_cnt_q <= '0;
            burst_q   <= '0;
            cs_q      <= '0;
            write_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cs_q     <= trans_cs_i;
                    write_q  <= trans_write_i;
                    burst_q  <= trans_burst_i;
                    ca_sel_q <= '0;
                    if (trans_valid_i) state_q <= ST_CMD;
                end
                ST_CMD: begin
                    if (ca_sel_q == 2'd2) begin
                        // Memory asks for double latency with RWDS high
                        lat_cnt_q <= hyper_rwds_i ? CNT_WIDTH'(2 * T_ACC - 1)
                                                  : CNT_WIDTH'(T_ACC - 1);
                        state_q   <= ST_LAT;
                    end else begin
                        ca_sel_q <= ca_sel_q + 2'd1;
                    end
                end
                ST_LAT: begin
                    if (lat_cnt_q == '0) begin
                        // Write fetches its first word with the clock stopped
                        state_q <= write_q ? ST_WSTALL : ST_RDATA;
                    end else begin
                        lat_cnt_q <= lat_cnt_q - CNT_WIDTH'(1);
                    end
                end
                ST_WSTALL: begin
                    if (tx_valid_i) state_q <= ST_WDATA;
                end
                ST_WDATA: begin
                    burst_q <= burst_q - BURST_WIDTH'(1);
                    if (last_word_o) begin
                        rec_cnt_q <= CNT_WIDTH'(T_RWR - 1);
                        state_q   <= ST_RECOV;
                    end else if (!tx_valid_i) begin
                        state_q <= ST_WSTALL;
                    end
                end
                ST_RDATA: begin
                    if (rd_stall) begin
                        state_q <= ST_RSTALL;
                    end else begin
                        burst_q <= burst_q - BURST_WIDTH'(1);  // One word per enabled cycle
                        if (last_word_o) begin
                            rec_cnt_q <= CNT_WIDTH'(T_RWR - 1);
                            state_q   <= ST_RECOV;
                        end
                    end
                end
                ST_RSTALL: begin
                    if (rx_take_i) state_q <= ST_RDATA;
                end
                ST_RECOV: begin
                    if (rec_cnt_q == '0) state_q <= ST_IDLE;
                    else rec_cnt_q <= rec_cnt_q - CNT_WIDTH'(1);
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk0) begin
        if (state_q == ST_IDLE) addr_q <= trans_address_i;
    end

    assign cs_active = !(state_q inside {ST_IDLE, ST_RECOV});

    always_comb begin
        case (state_q)
            ST_CMD, ST_LAT, ST_WDATA: hyper_ck_en_o = 1'b1;
            ST_RDATA:                 hyper_ck_en_o = !rd_stall;  // Drop at once on back-pressure
            default:                  hyper_ck_en_o = 1'b0;
        endcase
    end

    assign hyper_cs_no    = cs_active ? ~cs_q : {NR_CS{1'b1}};
    assign trans_ready_o  = (state_q == ST_CMD) && (ca_sel_q == 2'd0);
    assign b_resp_valid_o = (state_q == ST_WDATA) && last_word_o;
    assign state_o        = state_q;
    assign ca_sel_o       = ca_sel_q;
    assign addr_o         = addr_q;
    assign read_o         = !write_q;

    // Chip select stays high through recovery before the next command
    a_cs_recovery: assert property (@(posedge clk0) disable iff (!rst_ni)
        $fell(&hyper_cs_no) |-> $past(&hyper_cs_no, T_RWR));

    // Handshake completes on the cycle right after leaving idle
    a_ready_first_cmd: assert property (@(posedge clk0) disable iff (!rst_ni)
        trans_ready_o |-> $past(state_q) == ST_IDLE && $past(trans_valid_i));

endmodule

//--- hyper_tx_path.sv
// Transmit data path
// Write word capture and DQ / RWDS output drive with enables
`timescale 1ns/1ns

module hyper_tx_path
    import hyper_pkg::*;
(
    input  logic                  clk0,
    input  logic                  rst_ni,

    input  hyper_state_t          state_i,
    input  logic                  last_word_i,
    input  logic [WORD_WIDTH-1:0] ca_word_i,

    input  logic                  tx_valid_i,
    input  logic [WORD_WIDTH-1:0] tx_data_i,
    input  logic [STRB_WIDTH-1:0] tx_strb_i,
    output logic                  tx_ready_o,

    output logic [WORD_WIDTH-1:0] hyper_dq_o,
    output logic                  hyper_dq_oe_o,
    output logic [STRB_WIDTH-1:0] hyper_rwds_o,
    output logic                  hyper_rwds_oe_o
);

    logic [WORD_WIDTH-1:0] wdata_q;
    logic [STRB_WIDTH-1:0] wstrb_q;
    logic                  wr_phase;

    assign wr_phase = state_i inside {ST_WDATA, ST_WSTALL};

    // No fetch while the final word is on the bus
    assign tx_ready_o = (state_i == ST_WSTALL) || (state_i == ST_WDATA && !last_word_i);

    always_ff @(posedge clk0) begin
        if (tx_valid_i && tx_ready_o) begin
            wdata_q <= tx_data_i;
            wstrb_q <= tx_strb_i;
        end
    end

    assign hyper_dq_oe_o   = (state_i == ST_CMD) || wr_phase;
    assign hyper_rwds_oe_o = wr_phase;

    assign hyper_dq_o   = (state_i == ST_CMD) ? ca_word_i : (wr_phase ? wdata_q : '0);
    assign hyper_rwds_o = wr_phase ? ~wstrb_q : '0;  // RWDS high masks the byte

    // Bus already released in the cycle before any read state
    a_no_drive_on_read: assert property (@(posedge clk0) disable iff (!rst_ni)
        state_i inside {ST_RDATA, ST_RSTALL} |-> !hyper_dq_oe_o && !hyper_rwds_oe_o
            && !$past(hyper_dq_oe_o) && !$past(hyper_rwds_oe_o));

endmodule

//--- hyper_rx_path.sv
// Receive data path
// One-word register for RWDS-marked read data on a valid/ready port
`timescale 1ns/1ns

module hyper_rx_path
    import hyper_pkg::*;
(
    input  logic                  clk0,
    input  logic                  rst_ni,

    input  hyper_state_t          state_i,
    input  logic                  last_word_i,

    input  logic [WORD_WIDTH-1:0] hyper_dq_i,
    input  logic                  hyper_rwds_i,

    input  logic                  rx_ready_i,
    output logic                  rx_valid_o,
    output logic [WORD_WIDTH-1:0] rx_data_o,
    output logic                  rx_last_o,
    output logic                  rx_full_o,
    output logic                  rx_take_o
);

    logic [WORD_WIDTH-1:0] data_q;
    logic                  valid_q;
    logic                  last_q;
    logic                  capture;

    assign rx_take_o = valid_q && rx_ready_i;

    // Never overwrite a word that has not been taken
    assign capture = (state_i == ST_RDATA) && hyper_rwds_i && (!valid_q || rx_ready_i);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
            last_q  <= last_word_i;
        end else if (rx_take_o) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk0) begin
        if (capture) data_q <= hyper_dq_i;
    end

    assign rx_valid_o = valid_q;
    assign rx_data_o  = data_q;
    assign rx_last_o  = last_q;
    assign rx_full_o  = valid_q;

    a_rx_hold: assert property (@(posedge clk0) disable iff (!rst_ni)
        rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o) && $stable(rx_last_o));

endmodule

//--- hyperbus_phy.sv
// HyperBus PHY top level
// Controller, command-address builder, transmit and receive paths
`timescale 1ns/1ns

module hyperbus_phy
    import hyper_pkg::*;
(
    input  logic                   clk0,
    input  logic                   rst_ni,

    // Transactions
    input  logic                   trans_valid_i,
    output logic                   trans_ready_o,
    input  logic [ADDR_WIDTH-1:0]  trans_address_i,
    input  logic [NR_CS-1:0]       trans_cs_i,
    input  logic                   trans_write_i,
    input  logic [BURST_WIDTH-1:0] trans_burst_i,

    // Write data
    input  logic                   tx_valid_i,
    output logic                   tx_ready_o,
    input  logic [WORD_WIDTH-1:0]  tx_data_i,
    input  logic [STRB_WIDTH-1:0]  tx_strb_i,

    // Read data
    output logic                   rx_valid_o,
    input  logic                   rx_ready_i,
    output logic [WORD_WIDTH-1:0]  rx_data_o,
    output logic                   rx_last_o,

    output logic                   b_resp_valid_o,

    // Bus side
    output logic [NR_CS-1:0]       hyper_cs_no,
    output logic                   hyper_ck_en_o,
    output logic [WORD_WIDTH-1:0]  hyper_dq_o,
    output logic                   hyper_dq_oe_o,
    input  logic [WORD_WIDTH-1:0]  hyper_dq_i,
    output logic [STRB_WIDTH-1:0]  hyper_rwds_o,
    output logic                   hyper_rwds_oe_o,
    input  logic                   hyper_rwds_i
);

    hyper_state_t          state;
    logic [1:0]            ca_sel;
    logic [WORD_WIDTH-1:0] ca_word;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  read;
    logic                  last_word;
    logic                  rx_full;
    logic                  rx_take;

    hyper_ctrl_fsm ctrl_fsm_inst (
        .clk0            ( clk0            ),
        .rst_ni          ( rst_ni          ),
        .trans_valid_i   ( trans_valid_i   ),
        .trans_ready_o   ( trans_ready_o   ),
        .trans_address_i ( trans_address_i ),
        .trans_write_i   ( trans_write_i   ),
        .trans_cs_i      ( trans_cs_i      ),
        .trans_burst_i   ( trans_burst_i   ),
        .tx_valid_i      ( tx_valid_i      ),
        .rx_full_i       ( rx_full         ),
        .rx_ready_i      ( rx_ready_i      ),
        .rx_take_i       ( rx_take         ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .state_o         ( state           ),
        .ca_sel_o        ( ca_sel          ),
        .last_word_o     ( last_word       ),
        .addr_o          ( addr            ),
        .read_o          ( read            ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_en_o   ( hyper_ck_en_o   ),
        .b_resp_valid_o  ( b_resp_valid_o  )
    );

    hyper_ca_gen ca_gen_inst (
        .read_i    ( read    ),
        .address_i ( addr    ),
        .ca_sel_i  ( ca_sel  ),
        .ca_word_o ( ca_word )
    );

    hyper_tx_path tx_path_inst (
        .clk0            ( clk0            ),
        .rst_ni          ( rst_ni          ),
        .state_i         ( state           ),
        .last_word_i     ( last_word       ),
        .ca_word_i       ( ca_word         ),
        .tx_valid_i      ( tx_valid_i      ),
        .tx_data_i       ( tx_data_i       ),
        .tx_strb_i       ( tx_strb_i       ),
        .tx_ready_o      ( tx_ready_o      ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o )
    );

    hyper_rx_path rx_path_inst (
        .clk0         ( clk0         ),
        .rst_ni       ( rst_ni       ),
        .state_i      ( state        ),
        .last_word_i  ( last_word    ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .hyper_rwds_i ( hyper_rwds_i ),
        .rx_ready_i   ( rx_ready_i   ),
        .rx_valid_o   ( rx_valid_o   ),
        .rx_data_o    ( rx_data_o    ),
        .rx_last_o    ( rx_last_o    ),
        .rx_full_o    ( rx_full      ),
        .rx_take_o    ( rx_take      )
    );

endmodule

//--- hyper_checker.sv
// Testbench monitor for the HyperBus PHY
// Checks command words, latency, write data, receive data and write responses
`timescale 1ns/1ns

module hyper_checker
    import hyper_pkg::*;
(
    input logic                  clk0,
    input logic                  rst_ni,
    input logic                  trans_ready_o,
    input logic [NR_CS-1:0]      hyper_cs_no,
    input logic                  hyper_ck_en_o,
    input logic [WORD_WIDTH-1:0] hyper_dq_o,
    input logic                  hyper_dq_oe_o,
    input logic [STRB_WIDTH-1:0] hyper_rwds_o,
    input logic                  hyper_rwds_oe_o,
    input logic                  hyper_rwds_i,
    input logic                  rx_valid_o,
    input logic                  rx_ready_i,
    input logic [WORD_WIDTH-1:0] rx_data_o,
    input logic                  rx_last_o,
    input logic                  b_resp_valid_o
);

    int errors = 0;

    // Pending transactions, oldest first
    logic                  q_write[$];
    logic [NR_CS-1:0]      q_cs[$];
    logic [ADDR_WIDTH-1:0] q_addr[$];
    int                    q_burst[$];
    logic                  q_extra[$];
    logic [WORD_WIDTH-1:0] q_wdata[$];
    logic [STRB_WIDTH-1:0] q_wstrb[$];

    logic                  cur_write;
    logic [CA_WIDTH-1:0]   cur_ca;
    int                    cur_lat;
    int                    trans_nr = 0;
    int                    idx = 0;
    int                    lat_cnt = 0;
    int                    b_cnt = 0;
    logic                  data_on = 1'b0;
    logic                  in_trans = 1'b0;
    logic [WORD_WIDTH-1:0] rd_base;
    int                    rd_burst = 0;
    int                    rd_idx = 0;
    logic [STRB_WIDTH-1:0] exp_mask;
    logic [WORD_WIDTH-1:0] exp_rd;

    task automatic expect_trans(input logic wr, input logic [NR_CS-1:0] cs,
                                input logic [ADDR_WIDTH-1:0] addr, input int burst,
                                input logic extra);
        q_write.push_back(wr);
        q_cs.push_back(cs);
        q_addr.push_back(addr);
        q_burst.push_back(burst);
        q_extra.push_back(extra);
    endtask

    task automatic expect_write_word(input logic [WORD_WIDTH-1:0] d,
                                     input logic [STRB_WIDTH-1:0] s);
        q_wdata.push_back(d);
        q_wstrb.push_back(s);
    endtask

    task automatic compare(input string name, input logic [CA_WIDTH-1:0] exp_v,
                           input logic [CA_WIDTH-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic start_trans(input logic [NR_CS-1:0] cs_n);
        logic [ADDR_WIDTH-1:0] a;
        logic [NR_CS-1:0]      cs_exp;
        trans_nr++;
        if (q_write.size() == 0) begin
            $display("Transaction started on the bus with none expected");
            errors++;
        end else begin
            cur_write = q_write.pop_front();
            a = q_addr.pop_front();
            cur_lat = q_extra.pop_front() ? 2 * T_ACC : T_ACC;
            // CA rule: read flag, memory space 0, linear burst 1, address split
            cur_ca = {!cur_write, 1'b0, 1'b1, a[31:3], 13'd0, a[2:0]};
            cs_exp = ~q_cs.pop_front();
            compare($sformatf("trans%0d chip select", trans_nr), CA_WIDTH'(cs_exp),
                    CA_WIDTH'(cs_n));
            if (!cur_write) begin
                rd_base  = a[15:0];
                rd_burst = q_burst[0];
                rd_idx   = 0;
            end
            void'(q_burst.pop_front());
        end
    endtask

    always @(posedge clk0) begin
        if (rst_ni && hyper_cs_no != {NR_CS{1'b1}}) begin
            in_trans = 1'b1;
            if (hyper_ck_en_o) begin
                if (idx == 0) start_trans(hyper_cs_no);
                if (idx < 3) begin
                    compare($sformatf("trans%0d command word %0d", trans_nr, idx),
                            CA_WIDTH'(cur_ca[47 - 16 * idx -: 16]), CA_WIDTH'(hyper_dq_o));
                    compare($sformatf("trans%0d command oe", trans_nr), 1, hyper_dq_oe_o);
                    compare($sformatf("trans%0d ready in command word %0d", trans_nr, idx),
                            (idx == 0) ? 1 : 0, trans_ready_o);
                end else begin
                    if (!data_on && (cur_write ? hyper_dq_oe_o : hyper_rwds_i)) begin
                        data_on = 1'b1;
                        compare($sformatf("trans%0d latency", trans_nr), cur_lat, lat_cnt);
                    end
                    if (!data_on) begin
                        lat_cnt++;
                    end else if (cur_write) begin
                        if (q_wdata.size() == 0) begin
                            $display("Write word on the bus that was never sent");
                            errors++;
                        end else begin
                            compare($sformatf("trans%0d write data", trans_nr),
                                    CA_WIDTH'(q_wdata.pop_front()), CA_WIDTH'(hyper_dq_o));
                            exp_mask = ~q_wstrb.pop_front();
                            compare($sformatf("trans%0d write mask", trans_nr),
                                    CA_WIDTH'(exp_mask), CA_WIDTH'(hyper_rwds_o));
                            compare($sformatf("trans%0d write mask oe", trans_nr), 1,
                                    hyper_rwds_oe_o);
                        end
                    end else begin
                        // Memory owns DQ and RWDS during read data
                        compare($sformatf("trans%0d read oe", trans_nr), 0,
                                {hyper_dq_oe_o, hyper_rwds_oe_o});
                    end
                end
                idx++;
            end
            // Back-pressure must stop the bus clock
            if (data_on && !cur_write && rx_valid_o && !rx_ready_i && hyper_ck_en_o) begin
                $display("Bus clock ran while the receive port was stalled");
                errors++;
            end
            if (b_resp_valid_o) b_cnt++;
        end else if (in_trans) begin
            if (cur_write)
                compare($sformatf("trans%0d write responses", trans_nr), 1, b_cnt);
            in_trans = 1'b0;
            idx      = 0;
            lat_cnt  = 0;
            b_cnt    = 0;
            data_on  = 1'b0;
        end
        if (rst_ni && rx_valid_o && rx_ready_i) begin
            exp_rd = rd_base + WORD_WIDTH'(rd_idx);
            compare($sformatf("trans%0d read data %0d", trans_nr, rd_idx),
                    CA_WIDTH'(exp_rd), CA_WIDTH'(rx_data_o));
            compare($sformatf("trans%0d read last %0d", trans_nr, rd_idx),
                    (rd_idx == rd_burst - 1) ? 1 : 0, rx_last_o);
            rd_idx++;
        end
    end

    task automatic final_check();
        if (q_write.size() != 0 || q_wdata.size() != 0) begin
            $display("Expected transactions or write words never appeared on the bus");
            errors++;
        end
        compare("final read count", rd_burst, rd_idx);
    endtask

endmodule

//--- tb_hyperbus_phy.sv
// Testbench for the HyperBus PHY
// Clock, reset, file-driven stimulus, memory model and closing report
`timescale 1ns/1ns

module tb_hyperbus_phy
    import hyper_pkg::*;
;

    logic                   clk0 = 1'b0;
    logic                   rst_ni = 1'b0;
    logic                   trans_valid_i = 1'b0;
    logic                   trans_ready_o;
    logic [ADDR_WIDTH-1:0]  trans_address_i = '0;
    logic [NR_CS-1:0]       trans_cs_i = '0;
    logic                   trans_write_i = 1'b0;
    logic [BURST_WIDTH-1:0] trans_burst_i = '0;
    logic                   tx_valid_i = 1'b0;
    logic                   tx_ready_o;
    logic [WORD_WIDTH-1:0]  tx_data_i = '0;
    logic [STRB_WIDTH-1:0]  tx_strb_i = '0;
    logic                   rx_valid_o;
    logic                   rx_ready_i = 1'b1;
    logic [WORD_WIDTH-1:0]  rx_data_o;
    logic                   rx_last_o;
    logic                   b_resp_valid_o;
    logic [NR_CS-1:0]       hyper_cs_no;
    logic                   hyper_ck_en_o;
    logic [WORD_WIDTH-1:0]  hyper_dq_o;
    logic                   hyper_dq_oe_o;
    logic [WORD_WIDTH-1:0]  hyper_dq_i;
    logic [STRB_WIDTH-1:0]  hyper_rwds_o;
    logic                   hyper_rwds_oe_o;
    logic                   hyper_rwds_i;

    // Memory model state
    logic [ADDR_WIDTH-1:0]  model_addr = '0;
    logic                   model_read = 1'b0;
    logic                   model_extra = 1'b0;
    int                     model_cnt;
    int                     model_lat;
    logic                   timed_out = 1'b0;

    always #2 clk0 = ~clk0;

    hyperbus_phy hyperbus_phy_inst (.*);

    hyper_checker monitor_inst (
        .clk0, .rst_ni, .trans_ready_o, .hyper_cs_no, .hyper_ck_en_o, .hyper_dq_o,
        .hyper_dq_oe_o, .hyper_rwds_o, .hyper_rwds_oe_o, .hyper_rwds_i, .rx_valid_o,
        .rx_ready_i, .rx_data_o, .rx_last_o, .b_resp_valid_o
    );

    // Enabled bus cycles since chip select fell
    always @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) model_cnt <= 0;
        else if (&hyper_cs_no) model_cnt <= 0;
        else if (hyper_ck_en_o) model_cnt <= model_cnt + 1;
    end

    always_comb begin
        model_lat    = model_extra ? 2 * T_ACC : T_ACC;
        hyper_rwds_i = !(&hyper_cs_no) && ((model_cnt == 2 && model_extra)
                       || (model_read && hyper_ck_en_o && model_cnt >= 3 + model_lat));
        hyper_dq_i   = '0;
        if (hyper_rwds_i && model_cnt >= 3)
            hyper_dq_i = model_addr[15:0] + WORD_WIDTH'(model_cnt - 3 - model_lat);
    end

    task automatic issue_trans(input int op, input int cs, input logic [31:0] addr,
                               input int burst, input int extra);
        int   t;
        logic seen;
        t    = 0;
        seen = 1'b0;
        monitor_inst.expect_trans(op == 0, NR_CS'(cs), addr, burst, extra != 0);
        @(negedge clk0);
        model_addr      = addr;
        model_read      = (op != 0);
        model_extra     = (extra != 0);
        trans_address_i = addr;
        trans_cs_i      = NR_CS'(cs);
        trans_write_i   = (op == 0);
        trans_burst_i   = BURST_WIDTH'(burst);
        trans_valid_i   = 1'b1;
        while (!seen && !timed_out) begin
            @(posedge clk0);
            if (trans_ready_o) seen = 1'b1;
            else if (++t > 200) begin
                $display("Timeout: transaction at %h was never accepted", addr);
                timed_out = 1'b1;
            end
        end
        @(negedge clk0);
        trans_valid_i = 1'b0;
    endtask

    task automatic run_write(input int burst, input logic [7:0] gaps);
        int                    sent;
        int                    t;
        int                    k;
        logic                  got_b;
        logic [WORD_WIDTH-1:0] d;
        logic [STRB_WIDTH-1:0] s;
        sent  = 0;
        t     = 0;
        k     = 0;
        got_b = 1'b0;
        d     = WORD_WIDTH'($urandom);
        s     = STRB_WIDTH'($urandom);
        while (sent < burst && !timed_out) begin
            @(negedge clk0);
            tx_valid_i = !gaps[k % 8];  // Gap bits hold tx_valid low
            tx_data_i  = d;
            tx_strb_i  = s;
            k++;
            @(posedge clk0);
            if (tx_valid_i && tx_ready_o) begin
                monitor_inst.expect_write_word(d, s);
                sent++;
                t = 0;
                d = WORD_WIDTH'($urandom);
                s = STRB_WIDTH'($urandom);
            end else if (++t > 200) begin
                $display("Timeout: write word %0d was never accepted", sent);
                timed_out = 1'b1;
            end
        end
        @(negedge clk0);
        tx_valid_i = 1'b0;
        t = 0;
        while (!got_b && !timed_out) begin
            @(posedge clk0);
            if (b_resp_valid_o) got_b = 1'b1;
            else if (++t > 50) begin
                $display("Timeout: no write response after the last word");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_read(input int burst, input logic [7:0] stalls);
        int got;
        int t;
        int k;
        got = 0;
        t   = 0;
        k   = 0;
        while (got < burst && !timed_out) begin
            @(negedge clk0);
            rx_ready_i = !stalls[k % 8];
            k++;
            @(posedge clk0);
            if (rx_valid_o && rx_ready_i) begin
                got++;
                t = 0;
            end else if (++t > 200) begin
                $display("Timeout: read word %0d never arrived", got);
                timed_out = 1'b1;
            end
        end
        @(negedge clk0);
        rx_ready_i = 1'b1;
    endtask

    initial begin
        int      fd;
        int      op;
        int      cs;
        int      burst;
        int      extra;
        int      pat;
        int      fields;
        logic [31:0] addr;
        string   line;
        void'($urandom(32'h7200_72a6));
        fd = $fopen("hyper_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file hyper_stim.txt could not be opened");
            timed_out = 1'b1;
        end
        repeat (16) @(posedge clk0);
        @(negedge clk0);
        rst_ni = 1'b1;
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h", op, cs, addr, burst, extra, pat);
                if (fields == 6) begin
                    issue_trans(op, cs, addr, burst, extra);
                    if (op == 0) run_write(burst, 8'(pat));
                    else run_read(burst, 8'(pat));
                end
            end
        end
        repeat (10) @(posedge clk0);
        monitor_inst.final_check();
        $display("Check errors: %0d, timeouts: %0d", monitor_inst.errors, timed_out ? 1 : 0);
        if (monitor_inst.errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hyper_stim.txt
# op cs addr burst extra stall, all hex
# op 0 write 1 read; cs one-hot; stall bits drop tx_valid or rx_ready per cycle
0 1 00001000 4 0 00
1 1 00001000 4 0 00
0 2 8000a5a6 8 1 00
1 2 8000a5a6 8 1 00
1 1 0001fff8 6 0 5a
1 2 12345677 5 1 e7
0 1 00200013 6 0 24
0 2 7ffffffe 3 1 c3
1 1 00000000 1 0 0f
0 1 0000beef 1 0 01
1 2 fedcba90 a 0 33
0 2 00fff000 5 1 6c
1 1 000c0de5 7 1 81

//--- all.f
hyper_pkg.sv
hyper_ca_gen.sv
hyper_ctrl_fsm.sv
hyper_tx_path.sv
hyper_rx_path.sv
hyperbus_phy.sv
hyper_checker.sv
tb_hyperbus_phy.sv

//--- run.sh
#!/bin/sh
# Build and run the HyperBus PHY testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_hyperbus_phy -f all.f

out=$(./obj_dir/Vtb_hyperbus_phy)
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1
